// ==== tb.f ====
+incdir+logic
logic/throw_pkg.sv
logic/throw_regs.sv
logic/horiz_motion.sv
logic/vert_motion.sv
logic/flight_tracker.sv
logic/throw_engine_top.sv
verification/throw_engine_tb.sv

// ==== verification/throw_golden.txt ====
# one throw per line with force wind velocity landing_x flight_ticks
# all values decimal and wind above 100 lands as 100
100 50 10 518 21
200 60 5 976 11
150 30 8 -421 17
37 47 3 168 7
0 100 0 140 1
1023 50 0 324 1
55 120 12 1740 25
300 0 2 -1090 5
13 71 50 847 101
1 0 57 25 115

// ==== verification/throw_engine_tb.sv ====
`timescale 1ns/10ps

`include "throw_cfg.svh"

module throw_engine_tb;

    localparam int CLK_PERIOD      = 8;
    localparam int HANDSHAKE_LIMIT = 32;   // cycles before a bus wait gives up.
    localparam int MAX_LINES       = 64;
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [`THROW_ADDR_W-1:0] ADDR_UNMAPPED = 'h20;

    logic clk = 1'b0;
    logic rst;
    logic [`THROW_ADDR_W-1:0] awaddr;
    logic [`THROW_ADDR_W-1:0] araddr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [3:0]  wstrb;
    logic [1:0]  bresp;
    logic [1:0]  rresp;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;

    int golden_force [MAX_LINES];
    int golden_wind [MAX_LINES];
    int golden_vel [MAX_LINES];
    int golden_x [MAX_LINES];
    int golden_ticks [MAX_LINES];
    int n_lines;
    bit file_loaded;

    throw_engine_top i_dut (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected 0x%h, got 0x%h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected 0x%h, got 0x%h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_state(input string name, input throw_pkg::flight_state_t exp,
                               input throw_pkg::flight_state_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected 0x%h, got 0x%h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_pos(input string name, input throw_pkg::pos_word_u exp,
                             input throw_pkg::pos_word_u act);
        if (act.flight_pos.x !== exp.flight_pos.x) begin
            $display("MISMATCH %s.flight_pos.x: expected 0x%h, got 0x%h",
                     name, exp.flight_pos.x, act.flight_pos.x);
            fail_run();
        end
        if (act.flight_pos.y !== exp.flight_pos.y) begin
            $display("MISMATCH %s.flight_pos.y: expected 0x%h, got 0x%h",
                     name, exp.flight_pos.y, act.flight_pos.y);
            fail_run();
        end
        if (act.landing.ticks !== exp.landing.ticks) begin
            $display("MISMATCH %s.landing.ticks: expected 0x%h, got 0x%h",
                     name, exp.landing.ticks, act.landing.ticks);
            fail_run();
        end
        if (act.landing.land_x !== exp.landing.land_x) begin
            $display("MISMATCH %s.landing.land_x: expected 0x%h, got 0x%h",
                     name, exp.landing.land_x, act.landing.land_x);
            fail_run();
        end
    endtask

    // outputs are sampled at the edge before the DUT updates them.
    task automatic axil_write(input logic [`THROW_ADDR_W-1:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int waited;
        waited = 0;
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= 4'hF;
        wvalid  <= 1'b1;
        bready  <= 1'b1;
        do begin
            @(posedge clk);
            waited++;
        end while (!(awready && wready) && waited < HANDSHAKE_LIMIT);
        if (!(awready && wready)) begin
            $display("ERROR: write to 0x%h was never accepted", addr);
            fail_run();
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!bvalid && waited < HANDSHAKE_LIMIT);
        if (!bvalid) begin
            $display("ERROR: write to 0x%h got no response", addr);
            fail_run();
        end
        resp = bresp;
        bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [`THROW_ADDR_W-1:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int waited;
        waited = 0;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= 1'b1;
        do begin
            @(posedge clk);
            waited++;
        end while (!arready && waited < HANDSHAKE_LIMIT);
        if (!arready) begin
            $display("ERROR: read of 0x%h was never accepted", addr);
            fail_run();
        end
        arvalid <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!rvalid && waited < HANDSHAKE_LIMIT);
        if (!rvalid) begin
            $display("ERROR: read of 0x%h returned no data", addr);
            fail_run();
        end
        data = rdata;
        resp = rresp;
        rready <= 1'b0;
    endtask

    task automatic write_reg(input logic [`THROW_ADDR_W-1:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axil_write(addr, data, resp);
        check_resp("bresp", RESP_OKAY, resp);
    endtask

    task automatic read_reg(input logic [`THROW_ADDR_W-1:0] addr, output logic [31:0] data);
        logic [1:0] resp;
        axil_read(addr, data, resp);
        check_resp("rresp", RESP_OKAY, resp);
    endtask

    task automatic read_expect(input string name, input logic [`THROW_ADDR_W-1:0] addr,
                               input logic [31:0] exp);
        logic [31:0] data;
        read_reg(addr, data);
        check_word(name, exp, data);
    endtask

    task automatic expect_state(input throw_pkg::flight_state_t exp);
        logic [31:0] data;
        read_reg(throw_pkg::REG_STATUS, data);
        check_state("state", exp, throw_pkg::flight_state_t'(data[1:0]));
        check_word("status upper bits", 32'h0, data & ~32'h3);
    endtask

    task automatic expect_launch_point();
        logic [31:0] data;
        throw_pkg::pos_word_u exp;
        throw_pkg::pos_word_u act;
        exp = '0;
        exp.flight_pos.x = 16'(`THROW_LAUNCH_X);
        exp.flight_pos.y = 16'(`THROW_LAUNCH_Y);
        read_reg(throw_pkg::REG_POSITION, data);
        act = data;
        check_pos("position", exp, act);
    endtask

    task automatic wait_landed();
        logic [31:0] data;
        throw_pkg::flight_state_t st;
        st = throw_pkg::ST_FLIGHT;
        while (st != throw_pkg::ST_LANDED) begin
            read_reg(throw_pkg::REG_STATUS, data);
            st = throw_pkg::flight_state_t'(data[1:0]);
            if (st == throw_pkg::ST_IDLE) begin
                $display("ERROR: state went back to idle before the throw landed");
                fail_run();
            end
        end
    endtask

    task automatic run_throw(input int idx, input bit relaunch);
        logic [31:0] data;
        throw_pkg::pos_word_u exp;
        throw_pkg::pos_word_u act;
        write_reg(throw_pkg::REG_FORCE, golden_force[idx]);
        write_reg(throw_pkg::REG_WIND, golden_wind[idx]);
        write_reg(throw_pkg::REG_VELOCITY, golden_vel[idx]);
        write_reg(throw_pkg::REG_CTRL, 32'h1);
        if (relaunch) begin
            expect_state(throw_pkg::ST_FLIGHT);
            // a restart would pick up this speed.
            write_reg(throw_pkg::REG_VELOCITY, 32'((golden_vel[idx] + 1) % 64));
            write_reg(throw_pkg::REG_CTRL, 32'h1); // must not restart.
        end
        wait_landed();
        exp = '0;
        exp.landing.ticks  = 16'(golden_ticks[idx]);
        exp.landing.land_x = 16'(golden_x[idx]);
        read_reg(throw_pkg::REG_POSITION, data);
        act = data;
        check_pos("landing", exp, act);
        write_reg(throw_pkg::REG_CTRL, 32'h2); // rearm.
        expect_state(throw_pkg::ST_IDLE);
        expect_launch_point();
    endtask

    task automatic load_golden();
        int fd;
        int n;
        int f, w, v, x, t;
        string line;
        fd = $fopen("verification/throw_golden.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open verification/throw_golden.txt");
            fail_run();
        end
        n_lines = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%d %d %d %d %d", f, w, v, x, t);
                if (n == 5 && n_lines < MAX_LINES) begin
                    golden_force[n_lines] = f;
                    golden_wind[n_lines]  = w;
                    golden_vel[n_lines]   = v;
                    golden_x[n_lines]     = x;
                    golden_ticks[n_lines] = t;
                    n_lines++;
                end
            end
        end
        $fclose(fd);
        if (n_lines == 0) begin
            $display("ERROR: golden file holds no throws");
            fail_run();
        end
        file_loaded = 1'b1;
    endtask

    // longest throw is 2*63+1 ticks. one extra throw for the relaunch case.
    initial begin
        longint limit_ns;
        wait (file_loaded);
        limit_ns = longint'(n_lines + 1) * (2 * 63 + 1) * `THROW_TICK_DIV * CLK_PERIOD + 20000;
        #(limit_ns);
        $display("ERROR: timeout after %0d ns, the throw never landed", limit_ns);
        fail_run();
    end

    initial begin
        logic [1:0]  resp;
        logic [31:0] data;
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        file_loaded = 1'b0;
        load_golden();
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        expect_state(throw_pkg::ST_IDLE);
        expect_launch_point();

        write_reg(throw_pkg::REG_FORCE, 32'h155);
        write_reg(throw_pkg::REG_WIND, 32'd33);
        write_reg(throw_pkg::REG_VELOCITY, 32'h2A);
        read_expect("force", throw_pkg::REG_FORCE, 32'h155);
        read_expect("wind", throw_pkg::REG_WIND, 32'd33);
        read_expect("velocity", throw_pkg::REG_VELOCITY, 32'h2A);
        write_reg(throw_pkg::REG_WIND, 32'd120);
        read_expect("wind clamp", throw_pkg::REG_WIND, 32'd100);

        for (int i = 0; i < n_lines; i++) begin
            run_throw(i, 1'b0);
        end
        run_throw(0, 1'b1);

        // rearm while idle.
        write_reg(throw_pkg::REG_CTRL, 32'h2);
        expect_state(throw_pkg::ST_IDLE);
        expect_launch_point();

        write_reg(throw_pkg::REG_FORCE, 32'h0AB);
        write_reg(throw_pkg::REG_WIND, 32'd77);
        write_reg(throw_pkg::REG_VELOCITY, 32'd9);
        axil_write(ADDR_UNMAPPED, 32'h3, resp);
        check_resp("bresp unmapped", RESP_SLVERR, resp);
        axil_read(ADDR_UNMAPPED, data, resp);
        check_resp("rresp unmapped", RESP_SLVERR, resp);
        axil_write(throw_pkg::REG_STATUS, 32'h2, resp);
        check_resp("bresp status", RESP_SLVERR, resp);
        axil_write(throw_pkg::REG_POSITION, 32'hFFFF_FFFF, resp);
        check_resp("bresp position", RESP_SLVERR, resp);
        read_expect("force", throw_pkg::REG_FORCE, 32'h0AB);
        read_expect("wind", throw_pkg::REG_WIND, 32'd77);
        read_expect("velocity", throw_pkg::REG_VELOCITY, 32'd9);
        read_expect("ctrl", throw_pkg::REG_CTRL, 32'h0);
        expect_state(throw_pkg::ST_IDLE);
        expect_launch_point();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== logic/throw_engine_top.sv ====
`timescale 1ns/10ps

`include "throw_cfg.svh"

module throw_engine_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`THROW_ADDR_W-1:0] awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [31:0]              wdata,
    input  logic [3:0]               wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [`THROW_ADDR_W-1:0] araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [31:0]              rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready
);

    logic [9:0]                     throw_force;
    logic [6:0]                     wind;
    logic [5:0]                     velocity;
    logic                           launch_req;
    logic                           rearm_req;
    logic                           start;
    logic                           step;
    logic                           ground_hit;
    logic signed [`THROW_POS_W-1:0] x_pos;
    logic signed [`THROW_POS_W-1:0] y_pos;
    throw_pkg::flight_state_t       state;
    throw_pkg::pos_word_u           pos_word;

    throw_regs i_regs (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .throw_force(throw_force), .wind(wind), .velocity(velocity),
        .launch_req(launch_req), .rearm_req(rearm_req),
        .state(state), .pos_word(pos_word)
    );

    // the two axes step side by side.
    horiz_motion i_horiz (
        .clk(clk), .rst(rst), .start(start), .step(step),
        .throw_force(throw_force), .wind(wind), .x_pos(x_pos)
    );

    vert_motion i_vert (
        .clk(clk), .rst(rst), .start(start), .step(step),
        .velocity(velocity), .y_pos(y_pos), .ground_hit(ground_hit)
    );

    flight_tracker i_tracker (
        .clk(clk), .rst(rst),
        .launch_req(launch_req), .rearm_req(rearm_req), .ground_hit(ground_hit),
        .x_pos(x_pos), .y_pos(y_pos),
        .start(start), .step(step), .state(state), .pos_word(pos_word)
    );

endmodule

// ==== logic/flight_tracker.sv ====
`timescale 1ns/10ps

`include "throw_cfg.svh"

module flight_tracker (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           launch_req,
    input  logic                           rearm_req,
    input  logic                           ground_hit,
    input  logic signed [`THROW_POS_W-1:0] x_pos,
    input  logic signed [`THROW_POS_W-1:0] y_pos,
    output logic                           start,
    output logic                           step,
    output throw_pkg::flight_state_t       state,
    output throw_pkg::pos_word_u           pos_word
);

    localparam int POS_W = `THROW_POS_W;
    localparam int EXT_W = 16 - POS_W;
    localparam int DIV_W = $clog2(`THROW_TICK_DIV);
    localparam logic signed [POS_W-1:0] LAUNCH_X = `THROW_LAUNCH_X;
    localparam logic signed [POS_W-1:0] LAUNCH_Y = `THROW_LAUNCH_Y;

    logic [DIV_W-1:0]        div_cnt;
    logic [15:0]             tick_cnt;
    logic [15:0]             land_ticks;
    logic signed [POS_W-1:0] land_x;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= throw_pkg::ST_IDLE;
            start   <= 1'b0;
            step    <= 1'b0;
            div_cnt <= '0;
        end else begin
            start <= 1'b0;
            step  <= 1'b0;
            case (state)
                throw_pkg::ST_IDLE: begin
                    if (launch_req) begin
                        state   <= throw_pkg::ST_FLIGHT;
                        start   <= 1'b1;
                        div_cnt <= '0;
                    end
                end
                throw_pkg::ST_FLIGHT: begin
                    if (ground_hit) begin
                        state <= throw_pkg::ST_LANDED; // no step after contact.
                    end else if (div_cnt == DIV_W'(`THROW_TICK_DIV - 1)) begin
                        div_cnt <= '0;
                        step    <= 1'b1;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                throw_pkg::ST_LANDED: begin
                    if (rearm_req) begin
                        state <= throw_pkg::ST_IDLE;
                    end
                end
                default: state <= throw_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            tick_cnt <= '0;
        end else if (step) begin
            tick_cnt <= tick_cnt + 1'b1;
        end
        if (ground_hit) begin
            land_x     <= x_pos;
            land_ticks <= tick_cnt; // final step already counted.
        end
    end

    always_comb begin
        pos_word = '0;
        case (state)
            throw_pkg::ST_LANDED: begin
                pos_word.landing.ticks  = land_ticks;
                pos_word.landing.land_x = {{EXT_W{land_x[POS_W-1]}}, land_x};
            end
            throw_pkg::ST_FLIGHT: begin
                pos_word.flight_pos.x = {{EXT_W{x_pos[POS_W-1]}}, x_pos};
                pos_word.flight_pos.y = {{EXT_W{y_pos[POS_W-1]}}, y_pos};
            end
            default: begin
                pos_word.flight_pos.x = {{EXT_W{LAUNCH_X[POS_W-1]}}, LAUNCH_X};
                pos_word.flight_pos.y = {{EXT_W{LAUNCH_Y[POS_W-1]}}, LAUNCH_Y};
            end
        endcase
    end

    a_step_in_flight: assert property (@(posedge clk) disable iff (rst)
        step |-> state == throw_pkg::ST_FLIGHT);

    // motion units only land a throw that is in flight.
    a_hit_in_flight: assert property (@(posedge clk) disable iff (rst)
        ground_hit |-> state == throw_pkg::ST_FLIGHT);

endmodule

// ==== logic/vert_motion.sv ====
`timescale 1ns/10ps

`include "throw_cfg.svh"

module vert_motion (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           start,
    input  logic                           step,
    input  logic [5:0]                     velocity,
    output logic signed [`THROW_POS_W-1:0] y_pos,
    output logic                           ground_hit
);

    localparam int POS_W = `THROW_POS_W;
    localparam logic signed [POS_W-1:0] LAUNCH_Y = `THROW_LAUNCH_Y;
    localparam logic signed [POS_W-1:0] GRAVITY  = `THROW_GRAVITY;

    logic signed [POS_W-1:0] v;      // speed used by the next step.
    logic signed [POS_W-1:0] y_next;
    logic                    contact;

    assign y_next = y_pos + v;

    // a step that is no longer rising and ends at or below launch height.
    assign contact = (v <= 0) && (y_next <= LAUNCH_Y);

    always_ff @(posedge clk) begin
        if (start) begin
            v <= POS_W'(velocity);
        end else if (step) begin
            v <= v - GRAVITY;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            y_pos      <= LAUNCH_Y;
            ground_hit <= 1'b0;
        end else begin
            ground_hit <= 1'b0;
            if (start) begin
                y_pos <= LAUNCH_Y;
            end else if (step) begin
                if (contact) begin
                    y_pos      <= LAUNCH_Y; // clamp to ground.
                    ground_hit <= 1'b1;
                end else begin
                    y_pos <= y_next;
                end
            end
        end
    end

    // landing pulse lines up with the result of a step.
    a_hit_after_step: assert property (@(posedge clk) disable iff (rst)
        ground_hit |-> $past(step));

endmodule

// ==== logic/horiz_motion.sv ====
`timescale 1ns/10ps

`include "throw_cfg.svh"

module horiz_motion (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           start,
    input  logic                           step,
    input  logic [9:0]                     throw_force,
    input  logic [6:0]                     wind,
    output logic signed [`THROW_POS_W-1:0] x_pos
);

    localparam int POS_W = `THROW_POS_W;
    localparam logic signed [POS_W-1:0] LAUNCH_X = `THROW_LAUNCH_X;

    int                      base_dx;
    int                      wind_dx;
    logic signed [POS_W-1:0] dx;
    logic signed [POS_W-1:0] dx_hold;

    // both terms truncate toward zero.
    always_comb begin
        base_dx = (int'(throw_force) * `THROW_FORCE_PCT) / 100;
        wind_dx = ((int'(wind) - 50) * int'(throw_force)) / 50; // 50 is calm air.
    end

    assign dx = POS_W'(base_dx + wind_dx);

    // settings frozen for the whole throw.
    always_ff @(posedge clk) begin
        if (start) begin
            dx_hold <= dx;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            x_pos <= LAUNCH_X;
        end else if (start) begin
            x_pos <= LAUNCH_X;
        end else if (step) begin
            x_pos <= x_pos + dx_hold;
        end
    end

endmodule

// ==== logic/throw_regs.sv ====
`timescale 1ns/10ps

`include "throw_cfg.svh"

module throw_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`THROW_ADDR_W-1:0] awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [31:0]              wdata,
    input  logic [3:0]               wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [`THROW_ADDR_W-1:0] araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [31:0]              rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    output logic [9:0]               throw_force,
    output logic [6:0]               wind,
    output logic [5:0]               velocity,
    output logic                     launch_req,
    output logic                     rearm_req,
    input  throw_pkg::flight_state_t state,
    input  throw_pkg::pos_word_u     pos_word
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic        wr_accept;
    logic        wr_hs;
    logic        ar_accept;
    logic        rd_hs;
    logic [31:0] rd_data;
    logic        rd_err;

    // one transaction at a time per channel.
    assign wr_accept = awvalid && wvalid && !awready && !bvalid;
    assign wr_hs     = awvalid && awready && wvalid && wready;
    assign ar_accept = arvalid && !arready && !rvalid;
    assign rd_hs     = arvalid && arready;

    // write channel. wstrb is ignored.
    always_ff @(posedge clk) begin
        if (rst) begin
            awready     <= 1'b0;
            wready      <= 1'b0;
            bvalid      <= 1'b0;
            bresp       <= RESP_OKAY;
            throw_force <= '0;
            wind        <= '0;
            velocity    <= '0;
            launch_req  <= 1'b0;
            rearm_req   <= 1'b0;
        end else begin
            launch_req <= 1'b0;
            rearm_req  <= 1'b0;
            awready    <= wr_accept;
            wready     <= wr_accept;
            if (wr_hs) begin
                bvalid <= 1'b1;
                bresp  <= RESP_OKAY;
                case (awaddr)
                    throw_pkg::REG_CTRL: begin
                        launch_req <= wdata[0];
                        rearm_req  <= wdata[1];
                    end
                    throw_pkg::REG_FORCE:    throw_force <= wdata[9:0];
                    throw_pkg::REG_WIND:     wind <= (wdata > 32'd100) ? 7'd100 : wdata[6:0];
                    throw_pkg::REG_VELOCITY: velocity <= wdata[5:0];
                    default:                 bresp <= RESP_SLVERR; // status, position, unmapped.
                endcase
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_comb begin
        rd_data = '0;
        rd_err  = 1'b0;
        case (araddr)
            throw_pkg::REG_CTRL:     rd_data = '0; // commands read as zero.
            throw_pkg::REG_FORCE:    rd_data = 32'(throw_force);
            throw_pkg::REG_WIND:     rd_data = 32'(wind);
            throw_pkg::REG_VELOCITY: rd_data = 32'(velocity);
            throw_pkg::REG_STATUS:   rd_data = 32'(state);
            throw_pkg::REG_POSITION: rd_data = pos_word;
            default:                 rd_err  = 1'b1;
        endcase
    end

    // read channel, position sampled at the address handshake.
    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= RESP_OKAY;
        end else begin
            arready <= ar_accept;
            if (rd_hs) begin
                rvalid <= 1'b1;
                rdata  <= rd_data;
                rresp  <= rd_err ? RESP_SLVERR : RESP_OKAY;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp));

    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

// ==== logic/throw_pkg.sv ====
`include "throw_cfg.svh"

package throw_pkg;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_FLIGHT = 2'd1,
        ST_LANDED = 2'd2
    } flight_state_t;

    // register byte offsets.
    localparam logic [`THROW_ADDR_W-1:0] REG_CTRL     = 'h00;
    localparam logic [`THROW_ADDR_W-1:0] REG_FORCE    = 'h04;
    localparam logic [`THROW_ADDR_W-1:0] REG_WIND     = 'h08;
    localparam logic [`THROW_ADDR_W-1:0] REG_VELOCITY = 'h0C;
    localparam logic [`THROW_ADDR_W-1:0] REG_STATUS   = 'h10;
    localparam logic [`THROW_ADDR_W-1:0] REG_POSITION = 'h14;

    // live position while idle or in flight,
    // landing report once the throw is down.
    typedef union packed {
        struct packed {
            logic signed [15:0] x;
            logic signed [15:0] y;
        } flight_pos;
        struct packed {
            logic [15:0]        ticks;
            logic signed [15:0] land_x;
        } landing;
    } pos_word_u;

endpackage

// ==== logic/throw_cfg.svh ====
`ifndef THROW_CFG_SVH
`define THROW_CFG_SVH

// position width, signed x and y.
`define THROW_POS_W 12

// bus address width.
`define THROW_ADDR_W 8

// launch point in screen units.
`define THROW_LAUNCH_X 140
`define THROW_LAUNCH_Y 350

`define THROW_GRAVITY 1   // speed lost per tick.
`define THROW_FORCE_PCT 18   // horizontal force scale, percent.

// clock cycles per motion tick, 2 or more.
`define THROW_TICK_DIV 4

`endif
